//--- Makefile
TOP = tb_cu_control

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- cu_control.sv
// Copy accelerator control unit
module cu_control #(
	parameter int INDEX_BITS = 16,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                enabled_in,
	input  logic                job_valid,
	input  cu_pkg::addr_t       src_addr,
	input  cu_pkg::line_index_t src_lines,
	input  cu_pkg::addr_t       dst_addr,
	input  cu_pkg::line_index_t dst_lines,
	input  logic [15:0]         job_config,
	input  logic                read_buffer_full,
	input  logic                write_buffer_full,
	input  logic                read_rsp_valid,
	input  cu_pkg::line_index_t read_rsp_tag,
	input  mem_pkg::line_t      read_rsp_data,
	input  logic                write_rsp_valid,
	output logic                read_cmd_valid,
	output mem_pkg::cmd_code_t  read_cmd_code,
	output cu_pkg::addr_t       read_cmd_addr,
	output cu_pkg::line_index_t read_cmd_tag,
	output logic                write_cmd_valid,
	output mem_pkg::cmd_code_t  write_cmd_code,
	output cu_pkg::addr_t       write_cmd_addr,
	output mem_pkg::line_t      write_cmd_data,
	output cu_pkg::status_t     cu_status,
	output logic                cu_done,
	output logic                cu_running
);
	import cu_pkg::*;
	import mem_pkg::*;

	logic        enabled;
	logic        job_start;
	logic        job_active;
	logic        read_shared;
	addr_t       job_src_addr;
	addr_t       job_dst_addr;
	line_index_t job_src_lines;
	line_index_t job_dst_lines;
	count_t      read_count;
	count_t      write_count;
	logic        line_valid;
	line_index_t line_index;
	line_t       line_data;
	logic [7:0]  fifo_free;

	////////////////////
	// Job tracker
	////////////////////

	job_tracker #(
		.INDEX_BITS(INDEX_BITS)
	) job_tracker_instant (
		.clock        (clock        ),
		.rstn         (rstn         ),
		.enabled_in   (enabled_in   ),
		.job_valid    (job_valid    ),
		.src_addr     (src_addr     ),
		.dst_addr     (dst_addr     ),
		.src_lines    (src_lines    ),
		.dst_lines    (dst_lines    ),
		.job_config   (job_config   ),
		.read_count   (read_count   ),
		.write_count  (write_count  ),
		.enabled      (enabled      ),
		.job_start    (job_start    ),
		.job_active   (job_active   ),
		.read_shared  (read_shared  ),
		.job_src_addr (job_src_addr ),
		.job_dst_addr (job_dst_addr ),
		.job_src_lines(job_src_lines),
		.job_dst_lines(job_dst_lines),
		.cu_status    (cu_status    ),
		.cu_done      (cu_done      ),
		.cu_running   (cu_running   )
	);

	////////////////////
	// Read engine
	////////////////////

	read_stream_engine #(
		.INDEX_BITS(INDEX_BITS)
	) read_stream_engine_instant (
		.clock           (clock           ),
		.rstn            (rstn            ),
		.enabled         (enabled         ),
		.job_start       (job_start       ),
		.job_active      (job_active      ),
		.read_shared     (read_shared     ),
		.job_src_addr    (job_src_addr    ),
		.job_src_lines   (job_src_lines   ),
		.read_buffer_full(read_buffer_full),
		.fifo_free       (fifo_free       ),
		.read_rsp_valid  (read_rsp_valid  ),
		.read_rsp_tag    (read_rsp_tag    ),
		.read_rsp_data   (read_rsp_data   ),
		.read_cmd_valid  (read_cmd_valid  ),
		.read_cmd_code   (read_cmd_code   ),
		.read_cmd_addr   (read_cmd_addr   ),
		.read_cmd_tag    (read_cmd_tag    ),
		.line_valid      (line_valid      ),
		.line_index      (line_index      ),
		.line_data       (line_data       ),
		.read_count      (read_count      )
	);

	////////////////////
	// Write engine
	////////////////////

	write_stream_engine #(
		.INDEX_BITS(INDEX_BITS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) write_stream_engine_instant (
		.clock            (clock            ),
		.rstn             (rstn             ),
		.enabled          (enabled          ),
		.job_start        (job_start        ),
		.job_dst_addr     (job_dst_addr     ),
		.line_valid       (line_valid       ),
		.line_index       (line_index       ),
		.line_data        (line_data        ),
		.write_buffer_full(write_buffer_full),
		.write_rsp_valid  (write_rsp_valid  ),
		.fifo_free        (fifo_free        ),
		.write_cmd_valid  (write_cmd_valid  ),
		.write_cmd_code   (write_cmd_code   ),
		.write_cmd_addr   (write_cmd_addr   ),
		.write_cmd_data   (write_cmd_data   ),
		.write_count      (write_count      )
	);

endmodule

//--- cu_pkg.sv
// Copy unit job definitions
package cu_pkg;

	////////////////////
	// Job descriptor
	////////////////////

	// Widest line index a job can name
	localparam int LINE_INDEX_BITS = 16;

	// Configuration bit that selects shared reads
	localparam int CACHE_HINT_BIT = 3;

	// Line index and line count of a job
	typedef logic [LINE_INDEX_BITS-1:0] line_index_t;

	// Byte address in shared memory
	typedef logic [63:0] addr_t;

	////////////////////
	// Status layout
	////////////////////

	// Completion count of one side
	typedef logic [31:0] count_t;

	// Upper half write completions, lower half read completions
	typedef struct packed {
		count_t write_count;
		count_t read_count;
	} status_t;

endpackage

//--- job_tracker.sv
// Copy job tracker
module job_tracker #(
	parameter int INDEX_BITS = 16
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                enabled_in,
	input  logic                job_valid,
	input  cu_pkg::addr_t       src_addr,
	input  cu_pkg::addr_t       dst_addr,
	input  cu_pkg::line_index_t src_lines,
	input  cu_pkg::line_index_t dst_lines,
	input  logic [15:0]         job_config,
	input  cu_pkg::count_t      read_count,
	input  cu_pkg::count_t      write_count,
	output logic                enabled,
	output logic                job_start,
	output logic                job_active,
	output logic                read_shared,
	output cu_pkg::addr_t       job_src_addr,
	output cu_pkg::addr_t       job_dst_addr,
	output cu_pkg::line_index_t job_src_lines,
	output cu_pkg::line_index_t job_dst_lines,
	output cu_pkg::status_t     cu_status,
	output logic                cu_done,
	output logic                cu_running
);
	import cu_pkg::*;

	logic job_take;
	logic done_next;

	if (INDEX_BITS < 1 || INDEX_BITS > LINE_INDEX_BITS) begin : g_index_range
		$error("INDEX_BITS must lie between 1 and LINE_INDEX_BITS");
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	////////////////////
	// Job latch
	////////////////////

	assign job_take = job_valid && enabled;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			job_start   <= 1'b0;
			job_active  <= 1'b0;
			read_shared <= 1'b0;
		end else begin
			job_start <= job_take;
			if (job_take) begin
				job_active  <= 1'b1;
				read_shared <= job_config[CACHE_HINT_BIT];
			end
		end
	end

	// Sizes clipped to the largest job the index width allows
	always_ff @(posedge clock) begin
		if (job_take) begin
			job_src_addr  <= src_addr;
			job_dst_addr  <= dst_addr;
			job_src_lines <= line_index_t'(src_lines[INDEX_BITS-1:0]);
			job_dst_lines <= line_index_t'(dst_lines[INDEX_BITS-1:0]);
		end
	end

	////////////////////
	// Status and done
	////////////////////

	// Counts still belong to the previous job during job_start
	assign done_next = job_active && !job_start &&
		(read_count == count_t'(job_src_lines)) &&
		(write_count == count_t'(job_dst_lines));

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			cu_status  <= '0;
			cu_done    <= 1'b0;
			cu_running <= 1'b0;
		end else begin
			cu_status.write_count <= write_count;
			cu_status.read_count  <= read_count;
			cu_done               <= done_next;
			cu_running            <= job_active;
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) job_start |=> !job_start)
		else $error("job_start high on two consecutive cycles");

endmodule

//--- line_fifo.sv
// Pending write line queue
module line_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  push,
	input  logic                  pop,
	input  mem_pkg::write_entry_t push_entry,
	output mem_pkg::write_entry_t pop_entry,
	output logic                  empty,
	output logic [7:0]            free
);
	import mem_pkg::*;

	localparam int PTR_BITS   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(FIFO_DEPTH + 1);

	write_entry_t          entries [FIFO_DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  full;

	// Pointers wrap at the depth, which need not be a power of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			entries[wr_ptr] <= push_entry;
		end
	end

	assign pop_entry = entries[rd_ptr];
	assign empty     = (count == '0);
	assign full      = (count == COUNT_BITS'(FIFO_DEPTH));
	assign free      = 8'(FIFO_DEPTH) - 8'(count);

	// Credits upstream must keep the queue from overflowing
	assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("line_fifo push while full");

	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
		else $error("line_fifo pop while empty");

endmodule

//--- mem_pkg.sv
// Memory command and line definitions
package mem_pkg;

	////////////////////
	// Cache line
	////////////////////

	localparam int unsigned LINE_BYTES = 128;
	localparam int unsigned LINE_BITS  = LINE_BYTES * 8;

	// One full cache line of data
	typedef logic [LINE_BITS-1:0] line_t;

	////////////////////
	// Command codes
	////////////////////

	typedef enum logic [7:0] {
		CMD_NONE   = 8'h00,
		READ_CL_NA = 8'h0A,
		READ_CL_S  = 8'h0B,
		WRITE_MI   = 8'h0D
	} cmd_code_t;

	// Line waiting for its destination write
	typedef struct packed {
		cu_pkg::line_index_t index;
		line_t               data;
	} write_entry_t;

	// Address of line number index in an array at base
	function automatic cu_pkg::addr_t line_addr(
		input cu_pkg::addr_t       base,
		input cu_pkg::line_index_t index
	);
		cu_pkg::addr_t offset;
		offset = cu_pkg::addr_t'(index) * LINE_BYTES;
		return base + offset;
	endfunction

endpackage

//--- read_stream_engine.sv
// Source line read engine
module read_stream_engine #(
	parameter int INDEX_BITS = 16
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                enabled,
	input  logic                job_start,
	input  logic                job_active,
	input  logic                read_shared,
	input  cu_pkg::addr_t       job_src_addr,
	input  cu_pkg::line_index_t job_src_lines,
	input  logic                read_buffer_full,
	input  logic [7:0]          fifo_free,
	input  logic                read_rsp_valid,
	input  cu_pkg::line_index_t read_rsp_tag,
	input  mem_pkg::line_t      read_rsp_data,
	output logic                read_cmd_valid,
	output mem_pkg::cmd_code_t  read_cmd_code,
	output cu_pkg::addr_t       read_cmd_addr,
	output cu_pkg::line_index_t read_cmd_tag,
	output logic                line_valid,
	output cu_pkg::line_index_t line_index,
	output mem_pkg::line_t      line_data,
	output cu_pkg::count_t      read_count
);
	import cu_pkg::*;
	import mem_pkg::*;

	logic [INDEX_BITS-1:0] issue_index;
	logic [INDEX_BITS-1:0] start_index;
	logic [7:0]            outstanding;
	logic [7:0]            start_outstanding;
	logic                  lines_left;
	logic                  has_credit;
	logic                  issue;
	logic                  rsp_taken;

	////////////////////
	// Issue side
	////////////////////

	// A new job restarts the walk in its start cycle
	assign start_index       = job_start ? '0 : issue_index;
	assign start_outstanding = job_start ? '0 : outstanding;
	assign lines_left        = (start_index != job_src_lines[INDEX_BITS-1:0]);

	// Every read in flight owns one queue slot downstream
	assign has_credit = (start_outstanding < fifo_free);
	assign issue      = enabled && job_active && lines_left && has_credit && !read_buffer_full;
	assign rsp_taken  = read_rsp_valid && !job_start;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			issue_index <= '0;
			outstanding <= '0;
		end else begin
			if (issue) begin
				issue_index <= start_index + 1'b1;
			end else begin
				issue_index <= start_index;
			end
			case ({issue, rsp_taken})
				2'b10:   outstanding <= start_outstanding + 8'd1;
				2'b01:   outstanding <= start_outstanding - 8'd1;
				default: outstanding <= start_outstanding;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			read_cmd_valid <= 1'b0;
			read_cmd_code  <= CMD_NONE;
		end else begin
			read_cmd_valid <= issue;
			if (!issue) begin
				read_cmd_code <= CMD_NONE;
			end else if (read_shared) begin
				read_cmd_code <= READ_CL_S;
			end else begin
				read_cmd_code <= READ_CL_NA;
			end
		end
	end

	// Tag is the line index itself
	always_ff @(posedge clock) begin
		if (issue) begin
			read_cmd_tag  <= line_index_t'(start_index);
			read_cmd_addr <= line_addr(job_src_addr, line_index_t'(start_index));
		end
	end

	////////////////////
	// Response side
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			line_valid <= 1'b0;
			read_count <= '0;
		end else begin
			line_valid <= rsp_taken;
			if (job_start) begin
				read_count <= '0;
			end else if (rsp_taken) begin
				read_count <= read_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rsp_taken) begin
			line_index <= read_rsp_tag;
			line_data  <= read_rsp_data;
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> $past(!read_buffer_full))
		else $error("read command issued against a full read buffer");

endmodule

//--- src.f
cu_pkg.sv
mem_pkg.sv
line_fifo.sv
read_stream_engine.sv
write_stream_engine.sv
job_tracker.sv
cu_control.sv
tb_cu_control.sv

//--- tb_cu_control.sv
// Copy control unit testbench
module tb_cu_control;
	import cu_pkg::*;
	import mem_pkg::*;

	localparam int PERIOD    = 8;
	localparam int JOB_LINES = 6;
	localparam int JOB_COUNT = 6;
	localparam int MAX_LINES = 64;
	// Budget of 40 cycles per line of every job, plus the idle stretches
	localparam int WATCHDOG_CYCLES = JOB_COUNT * JOB_LINES * 40 + 200;

	logic        clock;
	logic        rstn;
	logic        enabled_in;
	logic        job_valid;
	addr_t       src_addr;
	line_index_t src_lines;
	addr_t       dst_addr;
	line_index_t dst_lines;
	logic [15:0] job_config;
	logic        read_buffer_full;
	logic        write_buffer_full;
	logic        read_rsp_valid;
	line_index_t read_rsp_tag;
	line_t       read_rsp_data;
	logic        write_rsp_valid;
	logic        read_cmd_valid;
	cmd_code_t   read_cmd_code;
	addr_t       read_cmd_addr;
	line_index_t read_cmd_tag;
	logic        write_cmd_valid;
	cmd_code_t   write_cmd_code;
	addr_t       write_cmd_addr;
	line_t       write_cmd_data;
	status_t     cu_status;
	logic        cu_done;
	logic        cu_running;

	// Expected job and scoreboard
	addr_t     exp_src;
	addr_t     exp_dst;
	int        exp_lines;
	cmd_code_t exp_read_code;
	bit        read_seen [MAX_LINES];
	bit        write_seen [MAX_LINES];
	bit        returned [MAX_LINES];
	line_t     sent_line [MAX_LINES];
	int        reads_issued;
	int        writes_issued;
	int        reads_returned;
	int        writes_acked;

	// Response counts as the status word shows them, two cycles behind
	status_t   status_lag1;
	status_t   status_lag2;

	// Memory model state
	logic [31:0] lfsr_state;
	line_index_t read_pending [$];
	int          write_owed;
	int          read_wait;
	int          write_wait;
	int          read_stall_left;
	int          write_stall_left;
	bit          stall_mode;
	int          cycle;
	int          last_ack_cycle;
	logic        read_full_seen;
	logic        write_full_seen;

	cu_control #(
		.INDEX_BITS(16),
		.FIFO_DEPTH(8)
	) uut (.*);

	initial clock = 1'b0;
	always #(PERIOD / 2) clock = ~clock;

	////////////////////
	// Random source
	////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic rand_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic random_line(output line_t line);
		for (int i = 0; i < LINE_BITS; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			line[i] = lfsr_state[0];
		end
	endtask

	////////////////////
	// Compare tasks
	////////////////////

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_cmd_code(input string name, input cmd_code_t actual,
			input cmd_code_t expected);
		if (actual !== expected) begin
			$display("Error: %s = %h, expected %h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
		if (actual !== expected) begin
			$display("Error: %s = %h, expected %h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_line(input string name, input line_t actual, input line_t expected);
		if (actual !== expected) begin
			$display("Error: %s = %h, expected %h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_status(input string name, input status_t actual,
			input status_t expected);
		if (actual !== expected) begin
			$display("Error: %s = %h, expected %h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("Error: %s = %h, expected %h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	////////////////////
	// Memory responder
	////////////////////

	always @(posedge clock) begin
		int          pick;
		logic [31:0] bits;
		line_t       data;
		line_index_t tag;
		cycle++;
		if (rstn !== 1'b1) begin
			read_rsp_valid  <= 1'b0;
			write_rsp_valid <= 1'b0;
		end else begin
			// A response is counted one cycle later and shown in status the cycle after
			status_lag2             = status_lag1;
			status_lag1.write_count = count_t'(writes_acked);
			status_lag1.read_count  = count_t'(reads_returned);

			// Reads answered in random order after random gaps
			read_rsp_valid <= 1'b0;
			if (read_wait > 0) begin
				read_wait--;
			end else if (read_pending.size() > 0) begin
				rand_bits(3, bits);
				pick = int'(bits) % read_pending.size();
				tag = read_pending[pick];
				read_pending.delete(pick);
				random_line(data);
				sent_line[int'(tag)] = data;
				returned[int'(tag)] = 1'b1;
				reads_returned++;
				read_rsp_valid <= 1'b1;
				read_rsp_tag   <= tag;
				read_rsp_data  <= data;
				rand_bits(2, bits);
				read_wait = int'(bits);
			end

			write_rsp_valid <= 1'b0;
			if (write_wait > 0) begin
				write_wait--;
			end else if (write_owed > 0) begin
				write_owed--;
				writes_acked++;
				last_ack_cycle = cycle;
				write_rsp_valid <= 1'b1;
				rand_bits(2, bits);
				write_wait = int'(bits);
			end

			// Buffer-full levels toggle after random stretches
			if (stall_mode) begin
				if (read_stall_left == 0) begin
					rand_bits(3, bits);
					read_stall_left = int'(bits) + 1;
					read_buffer_full <= ~read_buffer_full;
				end else begin
					read_stall_left--;
				end
				if (write_stall_left == 0) begin
					rand_bits(3, bits);
					write_stall_left = int'(bits) + 1;
					write_buffer_full <= ~write_buffer_full;
				end else begin
					write_stall_left--;
				end
			end else begin
				read_buffer_full  <= 1'b0;
				write_buffer_full <= 1'b0;
			end
		end
	end

	////////////////////
	// Command monitor
	////////////////////

	always @(negedge clock) begin
		int    idx;
		addr_t offset;
		if (read_cmd_valid === 1'b1) begin
			if (read_full_seen === 1'b1) begin
				report_failure("Read command issued while read_buffer_full was high");
			end
			idx = int'(read_cmd_tag);
			if (idx >= exp_lines || read_seen[idx]) begin
				report_failure($sformatf("Read tag %h is outside the job or repeated",
					read_cmd_tag));
			end
			check_cmd_code("read_cmd_code", read_cmd_code, exp_read_code);
			check_addr("read_cmd_addr", read_cmd_addr,
				exp_src + addr_t'(read_cmd_tag) * LINE_BYTES);
			read_seen[idx] = 1'b1;
			reads_issued++;
			read_pending.push_back(read_cmd_tag);
		end
		if (write_cmd_valid === 1'b1) begin
			if (write_full_seen === 1'b1) begin
				report_failure("Write command issued while write_buffer_full was high");
			end
			check_cmd_code("write_cmd_code", write_cmd_code, WRITE_MI);
			offset = write_cmd_addr - exp_dst;
			if (offset % LINE_BYTES != 0 || offset / LINE_BYTES >= addr_t'(exp_lines)) begin
				report_failure($sformatf("Write address %h is not a destination line",
					write_cmd_addr));
			end
			idx = int'(offset / LINE_BYTES);
			if (write_seen[idx] || !returned[idx]) begin
				report_failure($sformatf("Write to line %0d repeated or before its read", idx));
			end
			check_line("write_cmd_data", write_cmd_data, sent_line[idx]);
			write_seen[idx] = 1'b1;
			writes_issued++;
			write_owed++;
		end
		read_full_seen  = read_buffer_full;
		write_full_seen = write_buffer_full;
	end

	////////////////////
	// Job helpers
	////////////////////

	task automatic drive_job(input addr_t src, input addr_t dst, input logic [15:0] cfg);
		@(posedge clock);
		job_valid  <= 1'b1;
		src_addr   <= src;
		dst_addr   <= dst;
		src_lines  <= line_index_t'(JOB_LINES);
		dst_lines  <= line_index_t'(JOB_LINES);
		job_config <= cfg;
		@(posedge clock);
		job_valid  <= 1'b0;
	endtask

	task automatic start_job(input addr_t src, input addr_t dst, input logic [15:0] cfg);
		@(negedge clock);
		exp_src       = src;
		exp_dst       = dst;
		exp_lines     = JOB_LINES;
		exp_read_code = cfg[CACHE_HINT_BIT] ? READ_CL_S : READ_CL_NA;
		for (int i = 0; i < MAX_LINES; i++) begin
			read_seen[i]  = 1'b0;
			write_seen[i] = 1'b0;
			returned[i]   = 1'b0;
		end
		reads_issued   = 0;
		writes_issued  = 0;
		reads_returned = 0;
		writes_acked   = 0;
		drive_job(src, dst, cfg);
	endtask

	// Follows the status word until cu_done, then checks counts and the final word
	task automatic wait_done();
		status_t expected;
		@(posedge clock);
		@(negedge clock);
		check_bit("cu_done", cu_done, 1'b0);
		check_bit("cu_running", cu_running, 1'b1);
		// Status still shows the previous job for this one cycle
		@(negedge clock);
		while (cu_done !== 1'b1) begin
			check_bit("cu_running", cu_running, 1'b1);
			check_status("cu_status", cu_status, status_lag2);
			@(negedge clock);
		end
		if (cycle - last_ack_cycle != 2) begin
			report_failure("cu_done did not rise two cycles after the last write response");
		end
		if (reads_returned != exp_lines || writes_acked != exp_lines) begin
			report_failure("cu_done rose before every read and write response arrived");
		end
		if (reads_issued != exp_lines || writes_issued != exp_lines) begin
			report_failure("Number of read or write commands differs from the job size");
		end
		expected.write_count = count_t'(exp_lines);
		expected.read_count  = count_t'(exp_lines);
		check_status("cu_status", cu_status, expected);
	endtask

	task automatic copy_job(input addr_t src, input addr_t dst, input logic [15:0] cfg);
		start_job(src, dst, cfg);
		wait_done();
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic idle_after_reset();
		repeat (8) begin
			@(negedge clock);
			check_bit("read_cmd_valid", read_cmd_valid, 1'b0);
			check_bit("write_cmd_valid", write_cmd_valid, 1'b0);
			check_bit("cu_done", cu_done, 1'b0);
			check_bit("cu_running", cu_running, 1'b0);
			check_cmd_code("read_cmd_code", read_cmd_code, CMD_NONE);
			check_cmd_code("write_cmd_code", write_cmd_code, CMD_NONE);
			check_status("cu_status", cu_status, '0);
		end
	endtask

	task automatic disabled_job_ignored();
		drive_job(64'h0000_0010_0000_0000, 64'h0000_0020_0000_0000, 16'h0000);
		repeat (20) begin
			@(negedge clock);
			check_bit("read_cmd_valid", read_cmd_valid, 1'b0);
			check_bit("write_cmd_valid", write_cmd_valid, 1'b0);
			check_bit("cu_running", cu_running, 1'b0);
			check_status("cu_status", cu_status, '0);
		end
		@(posedge clock);
		enabled_in <= 1'b1;
		repeat (2) @(posedge clock);
		copy_job(64'h0000_0010_0000_0000, 64'h0000_0020_0000_0000, 16'h0000);
	endtask

	task automatic stalled_job();
		stall_mode = 1'b1;
		copy_job(64'h0000_0050_0000_2000, 64'h0000_0060_0000_3000, 16'h0000);
		stall_mode = 1'b0;
	endtask

	task automatic done_holds_until_next();
		status_t expected;
		expected.write_count = count_t'(JOB_LINES);
		expected.read_count  = count_t'(JOB_LINES);
		repeat (10) begin
			@(negedge clock);
			check_bit("cu_done", cu_done, 1'b1);
			check_status("cu_status", cu_status, expected);
		end
		copy_job(64'h0000_0070_0000_0000, 64'h0000_0080_0000_0400, 16'h0000);
	endtask

	initial begin
		lfsr_state        = 32'h26f2;
		rstn              = 1'b0;
		enabled_in        = 1'b0;
		job_valid         = 1'b0;
		src_addr          = '0;
		src_lines         = '0;
		dst_addr          = '0;
		dst_lines         = '0;
		job_config        = '0;
		read_buffer_full  = 1'b0;
		write_buffer_full = 1'b0;
		read_rsp_valid    = 1'b0;
		read_rsp_tag      = '0;
		read_rsp_data     = '0;
		write_rsp_valid   = 1'b0;
		exp_lines         = 0;
		stall_mode        = 1'b0;
		cycle             = 0;
		last_ack_cycle    = 0;
		status_lag1       = '0;
		status_lag2       = '0;
		repeat (3) @(posedge clock);
		rstn <= 1'b1;

		idle_after_reset();
		disabled_job_ignored();
		copy_job(64'h0000_0030_0000_0000, 64'h0000_0040_0000_0800, 16'h0000);
		// Cache hint set selects shared reads
		copy_job(64'h0000_0030_0001_0000, 64'h0000_0040_0001_0000, 16'h0008);
		stalled_job();
		done_holds_until_next();

		$display("*** TEST PASSED ***");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$fatal(1);
	end

endmodule

//--- write_stream_engine.sv
// Destination line write engine
module write_stream_engine #(
	parameter int INDEX_BITS = 16,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                enabled,
	input  logic                job_start,
	input  cu_pkg::addr_t       job_dst_addr,
	input  logic                line_valid,
	input  cu_pkg::line_index_t line_index,
	input  mem_pkg::line_t      line_data,
	input  logic                write_buffer_full,
	input  logic                write_rsp_valid,
	output logic [7:0]          fifo_free,
	output logic                write_cmd_valid,
	output mem_pkg::cmd_code_t  write_cmd_code,
	output cu_pkg::addr_t       write_cmd_addr,
	output mem_pkg::line_t      write_cmd_data,
	output cu_pkg::count_t      write_count
);
	import cu_pkg::*;
	import mem_pkg::*;

	logic         push;
	write_entry_t push_entry;
	write_entry_t pop_entry;
	logic         pop;
	logic         empty;
	logic [7:0]   free;
	logic [7:0]   in_flight;
	line_index_t  dst_index;

	////////////////////
	// Queue entry
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			push <= 1'b0;
		end else begin
			push <= line_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (line_valid) begin
			push_entry.index <= line_index;
			push_entry.data  <= line_data;
		end
	end

	line_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) line_fifo_instant (
		.clock     (clock     ),
		.rstn      (rstn      ),
		.push      (push      ),
		.pop       (pop       ),
		.push_entry(push_entry),
		.pop_entry (pop_entry ),
		.empty     (empty     ),
		.free      (free      )
	);

	// Lines already forwarded but not yet counted in the queue
	assign in_flight = {7'd0, push} + {7'd0, line_valid};
	assign fifo_free = (free > in_flight) ? (free - in_flight) : 8'd0;

	////////////////////
	// Write issue
	////////////////////

	assign pop       = enabled && !empty && !write_buffer_full;
	assign dst_index = line_index_t'(pop_entry.index[INDEX_BITS-1:0]);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			write_cmd_valid <= 1'b0;
			write_cmd_code  <= CMD_NONE;
		end else begin
			write_cmd_valid <= pop;
			write_cmd_code  <= pop ? WRITE_MI : CMD_NONE;
		end
	end

	// Same index on the destination side
	always_ff @(posedge clock) begin
		if (pop) begin
			write_cmd_addr <= line_addr(job_dst_addr, dst_index);
			write_cmd_data <= pop_entry.data;
		end
	end

	// Write completions
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			write_count <= '0;
		end else if (job_start) begin
			write_count <= '0;
		end else if (write_rsp_valid) begin
			write_count <= write_count + 1'b1;
		end
	end

endmodule
